// File: Bender.yml
package:
  name: soc_core

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/soc_pkg.sv
      - src/wb_switch.sv
      - src/onchip_ram.sv
      - src/gpio_leds.sv
      - src/tick_timer.sv
      - src/simple_pic.sv
      - src/soc_core.sv

  - target: test
    files:
      - bench/tb_soc_core.sv

// File: all.f
+incdir+src
src/soc_pkg.sv
src/wb_switch.sv
src/onchip_ram.sv
src/gpio_leds.sv
src/tick_timer.sv
src/simple_pic.sv
src/soc_core.sv
bench/tb_soc_core.sv

// File: bench/tb_soc_core.sv
// Table-driven testbench for soc_core acting as bus master and interrupt acknowledger
module tb_soc_core;

  localparam logic [2:0] OP_WRITE = 3'd0;
  localparam logic [2:0] OP_READ  = 3'd1;
  localparam logic [2:0] OP_INTA  = 3'd2;
  localparam logic [2:0] OP_PULSE = 3'd3;
  localparam logic [2:0] OP_WAIT  = 3'd4;
  localparam logic [2:0] OP_IDLE  = 3'd5;
  localparam logic [2:0] OP_LEDS  = 3'd6;

  localparam int ACK_WAIT  = 16;
  localparam int INTR_WAIT = 100;

  // One row of the stimulus table
  typedef struct packed {
    logic [2:0]     op;
    logic           tga;
    soc_pkg::addr_t adr;
    soc_pkg::word_t dat;
    soc_pkg::sel_t  sel;
    soc_pkg::word_t exp;
  } step_t;

  logic             clk = 1'b0;
  logic             reset;
  soc_pkg::wb_req_t m_req;
  soc_pkg::wb_rsp_t m_rsp;
  logic             inta;
  logic             intr;
  logic             irq_ext;
  logic [9:0]       sw;
  logic [13:0]      leds;

  step_t steps[$];
  int    cycle_cnt = 0;
  int    cycle_limit = 0;
  int    err_cnt = 0;
  int    pass_cnt = 0;
  int    fail_cnt = 0;
  logic  step_bad;

  always #2 clk = ~clk;

  soc_core i_dut (
    .wb_clk_i  (clk),
    .reset_i   (reset),
    .m_req_i   (m_req),
    .m_rsp_o   (m_rsp),
    .inta_i    (inta),
    .intr_o    (intr),
    .irq_ext_i (irq_ext),
    .sw_i      (sw),
    .leds_o    (leds)
  );

  // Watchdog on the whole run
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("The run timed out after %0d cycles", cycle_cnt);
      $display("Test failures found");
      $finish;
    end
  end

  function automatic void add_step(logic [2:0] op, logic tga, soc_pkg::addr_t adr,
                                   soc_pkg::word_t dat, soc_pkg::sel_t sel,
                                   soc_pkg::word_t exp);
    step_t s;
    s = '{op: op, tga: tga, adr: adr, dat: dat, sel: sel, exp: exp};
    steps.push_back(s);
  endfunction

  function automatic string op_name(logic [2:0] op);
    case (op)
      OP_WRITE: return "write";
      OP_READ:  return "read";
      OP_INTA:  return "inta";
      OP_PULSE: return "pulse";
      OP_WAIT:  return "wait";
      OP_IDLE:  return "idle";
      default:  return "leds";
    endcase
  endfunction

  function automatic void build_steps();
    soc_pkg::word_t w [6];
    for (int i = 0; i < 6; i++) begin
      w[i] = soc_pkg::word_t'($urandom());
    end
    // Timer alone, then external request alone; vector is 8 + line
    add_step(OP_WAIT,  1'b0, 19'h0, 16'h0, 2'b00, 16'h0001);
    add_step(OP_INTA,  1'b1, 19'h0, 16'h0, 2'b11, 16'h0008 + 16'd0);
    add_step(OP_WAIT,  1'b0, 19'h0, 16'h0, 2'b00, 16'h0000);
    add_step(OP_PULSE, 1'b0, 19'h0, 16'h0, 2'b00, 16'h0000);
    add_step(OP_WAIT,  1'b0, 19'h0, 16'h0, 2'b00, 16'h0001);
    add_step(OP_INTA,  1'b1, 19'h0, 16'h0, 2'b11, 16'h0008 + 16'd1);
    add_step(OP_WAIT,  1'b0, 19'h0, 16'h0, 2'b00, 16'h0000);
    // Both pending, idle long enough for the next timer tick
    add_step(OP_PULSE, 1'b0, 19'h0, 16'h0, 2'b00, 16'h0000);
    add_step(OP_IDLE,  1'b0, 19'h0, 16'd60, 2'b00, 16'h0000);
    add_step(OP_INTA,  1'b1, 19'h0, 16'h0, 2'b11, 16'h0008 + 16'd0);
    add_step(OP_INTA,  1'b1, 19'h0, 16'h0, 2'b11, 16'h0008 + 16'd1);
    add_step(OP_WAIT,  1'b0, 19'h0, 16'h0, 2'b00, 16'h0000);
    // RAM full words and byte lanes
    add_step(OP_WRITE, 1'b0, 19'h00010, w[0], 2'b11, 16'h0);
    add_step(OP_WRITE, 1'b0, 19'h00011, w[1], 2'b11, 16'h0);
    add_step(OP_WRITE, 1'b0, 19'h007ff, w[2], 2'b11, 16'h0);
    add_step(OP_READ,  1'b0, 19'h00010, 16'h0, 2'b11, w[0]);
    add_step(OP_READ,  1'b0, 19'h00011, 16'h0, 2'b11, w[1]);
    add_step(OP_READ,  1'b0, 19'h007ff, 16'h0, 2'b11, w[2]);
    add_step(OP_WRITE, 1'b0, 19'h00010, w[3], 2'b01, 16'h0);
    add_step(OP_READ,  1'b0, 19'h00010, 16'h0, 2'b11, {w[0][15:8], w[3][7:0]});
    add_step(OP_WRITE, 1'b0, 19'h00011, w[4], 2'b10, 16'h0);
    add_step(OP_READ,  1'b0, 19'h00011, 16'h0, 2'b11, {w[4][15:8], w[1][7:0]});
    // Aliases 256 words apart
    add_step(OP_READ,  1'b0, 19'h00110, 16'h0, 2'b11, {w[0][15:8], w[3][7:0]});
    add_step(OP_WRITE, 1'b0, 19'h04020, w[5], 2'b11, 16'h0);
    add_step(OP_READ,  1'b0, 19'h00020, 16'h0, 2'b11, w[5]);
    // Switches at I/O 0xf100, LEDs at 0xf102
    add_step(OP_READ,  1'b1, 19'h07880, 16'h0, 2'b11, {6'b0, sw});
    add_step(OP_WRITE, 1'b1, 19'h07881, 16'h3c5a, 2'b11, 16'h0);
    add_step(OP_LEDS,  1'b0, 19'h0, 16'h0, 2'b00, 16'h3c5a);
    add_step(OP_READ,  1'b1, 19'h07881, 16'h0, 2'b11, 16'h3c5a);
    add_step(OP_WRITE, 1'b1, 19'h07881, 16'hffff, 2'b01, 16'h0);
    add_step(OP_READ,  1'b1, 19'h07881, 16'h0, 2'b11, 16'h3cff);
    // Unmapped memory and I/O
    add_step(OP_READ,  1'b0, 19'h10000, 16'h0, 2'b11, 16'hffff);
    add_step(OP_READ,  1'b1, 19'h00020, 16'h0, 2'b11, 16'hffff);
    add_step(OP_WRITE, 1'b0, 19'h7ffff, w[1], 2'b11, 16'h0);
    add_step(OP_READ,  1'b0, 19'h7ffff, 16'h0, 2'b11, 16'hffff);
  endfunction

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%04h expected 0x%04h", name, got, exp);
      err_cnt++;
      step_bad = 1'b1;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("%s", msg);
    err_cnt++;
    step_bad = 1'b1;
  endtask

  // Holds the request until ack, then checks that ack does not repeat
  task automatic bus_transfer(input step_t s, output soc_pkg::word_t rdata,
                              output logic got_ack);
    soc_pkg::wb_req_t req;
    int waited;
    req     = '0;
    req.dat = s.dat;
    req.adr = s.adr;
    req.tga = s.tga;
    req.sel = s.sel;
    req.we  = (s.op == OP_WRITE);
    req.cyc = 1'b1;
    req.stb = 1'b1;
    rdata   = '0;
    got_ack = 1'b0;
    waited  = 0;
    @(posedge clk);
    m_req <= req;
    inta  <= (s.op == OP_INTA);
    while (!got_ack && waited < ACK_WAIT) begin
      @(negedge clk);
      if (m_rsp.ack) begin
        got_ack = 1'b1;
        rdata   = m_rsp.dat;
      end
      waited++;
    end
    // Address stays on the bus so the same slave's ack stays visible
    @(posedge clk);
    req.we  = 1'b0;
    req.cyc = 1'b0;
    req.stb = 1'b0;
    m_req <= req;
    inta  <= 1'b0;
    @(negedge clk);
    if (got_ack) begin
      check_value("m_rsp_o.ack", {15'b0, m_rsp.ack}, 16'h0000);
    end
  endtask

  task automatic pulse_ext();
    @(posedge clk);
    irq_ext <= 1'b1;
    @(posedge clk);
    irq_ext <= 1'b0;
  endtask

  task automatic wait_intr(input logic level, output logic seen);
    seen = 1'b0;
    for (int i = 0; i < INTR_WAIT && !seen; i++) begin
      @(negedge clk);
      seen = (intr === level);
    end
  endtask

  task automatic run_step(input int idx);
    step_t          s;
    soc_pkg::word_t rdata;
    logic           got_ack;
    logic           seen;
    s        = steps[idx];
    step_bad = 1'b0;
    case (s.op)
      OP_WRITE, OP_READ, OP_INTA: begin
        bus_transfer(s, rdata, got_ack);
        if (!got_ack) begin
          note_failure($sformatf("Step %0d got no acknowledge within %0d cycles",
                                 idx, ACK_WAIT));
        end else if (s.op != OP_WRITE) begin
          check_value("m_rsp_o.dat", rdata, s.exp);
        end
      end
      OP_PULSE: pulse_ext();
      OP_WAIT: begin
        wait_intr(s.exp[0], seen);
        if (!seen) begin
          note_failure($sformatf("Step %0d saw intr_o stay away from %0b for %0d cycles",
                                 idx, s.exp[0], INTR_WAIT));
        end
      end
      OP_IDLE: repeat (s.dat) @(posedge clk);
      default: begin
        @(negedge clk);
        check_value("leds_o", {2'b00, leds}, s.exp);
      end
    endcase
    if (step_bad) begin
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
    $display("Step %2d %-5s %s", idx, op_name(s.op), step_bad ? "FAIL" : "ok");
  endtask

  initial begin
    int unused_rnd;
    unused_rnd  = $urandom(32'h1b90_c5c1);
    reset       = 1'b1;
    m_req       = '0;
    inta        = 1'b0;
    irq_ext     = 1'b0;
    sw          = 10'h2a5;
    build_steps();
    cycle_limit = steps.size() * 20 + 200;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < steps.size(); i++) begin
      run_step(i);
    end
    $display("%0d steps, %0d passed, %0d failed, %0d errors",
             steps.size(), pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: src/gpio_leds.sv
// Switch input and LED output register Wishbone slave
module gpio_leds (
  input                    wb_clk_i,
  input                    reset_i,
  input  soc_pkg::wb_req_t req_i,
  output soc_pkg::wb_rsp_t rsp_o,
  input  [9:0]             sw_i,
  output [13:0]            leds_o
);

  logic [13:0]    leds_q;
  soc_pkg::word_t rd_q;
  logic           ack_q;
  logic           access;
  logic           led_sel;

  assign access  = req_i.cyc & req_i.stb & ~ack_q;

  // Word offset 0 is the switches, offset 1 the LEDs
  assign led_sel = req_i.adr[0];

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      ack_q  <= 1'b0;
      leds_q <= '0;
    end else begin
      ack_q <= access;
      if (access & req_i.we & led_sel) begin
        if (req_i.sel[0]) begin
          leds_q[7:0] <= req_i.dat[7:0];
        end
        if (req_i.sel[1]) begin
          leds_q[13:8] <= req_i.dat[13:8];
        end
      end
    end
  end

  // Read data captured alongside the ack
  always_ff @(posedge wb_clk_i) begin
    if (led_sel) begin
      rd_q <= {2'b00, leds_q};
    end else begin
      rd_q <= {6'b00_0000, sw_i};
    end
  end

  assign rsp_o.dat = rd_q;
  assign rsp_o.ack = ack_q;
  assign leds_o    = leds_q;

endmodule

// File: src/onchip_ram.sv
// Single-port word RAM Wishbone slave with byte lane writes
`include "soc_params.svh"

module onchip_ram (
  input                    wb_clk_i,
  input                    reset_i,
  input  soc_pkg::wb_req_t req_i,
  output soc_pkg::wb_rsp_t rsp_o
);

  localparam int DEPTH = 2 ** `RAM_ADDR_BITS;

  soc_pkg::word_t mem [DEPTH];

  logic [`RAM_ADDR_BITS-1:0] idx;
  soc_pkg::word_t            rd_q;
  logic                      ack_q;
  logic                      access;

  // Only the low address bits are decoded, so words alias
  assign idx = req_i.adr[`RAM_ADDR_BITS-1:0];

  // First cycle of a transfer, the ack cycle is excluded
  assign access = req_i.cyc & req_i.stb & ~ack_q;

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (access & req_i.we) begin
      if (req_i.sel[0]) begin
        mem[idx][7:0] <= req_i.dat[7:0];
      end
      if (req_i.sel[1]) begin
        mem[idx][15:8] <= req_i.dat[15:8];
      end
    end
    rd_q <= mem[idx];
  end

  assign rsp_o.dat = rd_q;
  assign rsp_o.ack = ack_q;

endmodule

// File: src/simple_pic.sv
// Edge-latching fixed-priority interrupt controller with acknowledge
module simple_pic (
  input                     wb_clk_i,
  input                     reset_i,
  input  soc_pkg::irq_vec_t irq_i,
  input                     inta_i,
  output                    intr_o,
  output soc_pkg::irq_id_t  iid_o
);

  soc_pkg::irq_vec_t irq_q;
  soc_pkg::irq_vec_t pend_q;
  soc_pkg::irq_vec_t rise;
  soc_pkg::irq_vec_t clr;
  soc_pkg::irq_id_t  iid;
  logic              inta_q;
  logic              inta_rise;

  // Edge detect on request lines and on the acknowledge
  assign rise      = irq_i & ~irq_q;
  assign inta_rise = inta_i & ~inta_q;

  // Lowest pending index has priority
  always_comb begin
    iid = '0;
    for (int i = 7; i >= 0; i--) begin
      if (pend_q[i]) begin
        iid = soc_pkg::irq_id_t'(i);
      end
    end
  end

  // Acknowledge clears the source currently presented
  always_comb begin
    clr = '0;
    if (inta_rise) begin
      clr[iid] = 1'b1;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      irq_q  <= '0;
      inta_q <= 1'b0;
      pend_q <= '0;
    end else begin
      irq_q  <= irq_i;
      inta_q <= inta_i;
      // A new edge wins over a clear of the same line
      pend_q <= (pend_q & ~clr) | rise;
    end
  end

  assign intr_o = |pend_q;
  assign iid_o  = iid;

endmodule

// File: src/soc_core.sv
// SoC top level with bus switch, RAM, GPIO, timer, interrupt controller and vector mux
module soc_core (
  input                    wb_clk_i,
  input                    reset_i,

  // Bus master port
  input  soc_pkg::wb_req_t m_req_i,
  output soc_pkg::wb_rsp_t m_rsp_o,

  // Interrupt handshake
  input                    inta_i,
  output                   intr_o,
  input                    irq_ext_i,

  // Board I/O
  input  [9:0]             sw_i,
  output [13:0]            leds_o
);

  soc_pkg::wb_req_t  ram_req;
  soc_pkg::wb_rsp_t  ram_rsp;
  soc_pkg::wb_req_t  gpio_req;
  soc_pkg::wb_rsp_t  gpio_rsp;
  soc_pkg::wb_rsp_t  sw_rsp;
  soc_pkg::irq_vec_t irq_vec;
  soc_pkg::irq_id_t  iid;
  logic              tick;

  wb_switch i_switch (
    .m_req_i  (m_req_i),
    .m_rsp_o  (sw_rsp),
    .s0_req_o (ram_req),
    .s0_rsp_i (ram_rsp),
    .s1_req_o (gpio_req),
    .s1_rsp_i (gpio_rsp)
  );

  onchip_ram i_ram (
    .wb_clk_i (wb_clk_i),
    .reset_i  (reset_i),
    .req_i    (ram_req),
    .rsp_o    (ram_rsp)
  );

  gpio_leds i_gpio (
    .wb_clk_i (wb_clk_i),
    .reset_i  (reset_i),
    .req_i    (gpio_req),
    .rsp_o    (gpio_rsp),
    .sw_i     (sw_i),
    .leds_o   (leds_o)
  );

  tick_timer i_timer (
    .wb_clk_i (wb_clk_i),
    .reset_i  (reset_i),
    .tick_o   (tick)
  );

  // Timer on line 0, external request on line 1, rest unused
  assign irq_vec = {6'b00_0000, irq_ext_i, tick};

  simple_pic i_pic (
    .wb_clk_i (wb_clk_i),
    .reset_i  (reset_i),
    .irq_i    (irq_vec),
    .inta_i   (inta_i),
    .intr_o   (intr_o),
    .iid_o    (iid)
  );

  // Interrupt acknowledge reads back vector 8 + id
  assign m_rsp_o.dat = inta_i ? {13'b0_0000_0000_0001, iid} : sw_rsp.dat;
  assign m_rsp_o.ack = sw_rsp.ack;

endmodule

// File: src/soc_params.svh
// Address map, RAM depth and timer period macros for the SoC bus fabric
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Decode key is {tga, adr}, 20 bits, tag bit on top

// Slave 0: on-chip RAM, memory space 0x00000 - 0x0ffff
`define S0_ADDR 20'b0_0000_0000_0000_0000_000
`define S0_MASK 20'b1_1111_0000_0000_0000_000

// Slave 1: switches and LEDs, I/O space 0xf100 - 0xf103
`define S1_ADDR 20'b1_0000_1111_0001_0000_000
`define S1_MASK 20'b1_0000_1111_1111_1111_110

// RAM depth as address bits, 256 words
`define RAM_ADDR_BITS 8

// Clock cycles between timer ticks
`define TIMER_PERIOD 64

`endif

// File: src/soc_pkg.sv
// Bus word types and Wishbone request/response structs
package soc_pkg;

  // 16-bit data word
  typedef logic [15:0] word_t;

  // Word address, byte address bits 19 to 1
  typedef logic [18:0] addr_t;

  // Byte lane select, bit 0 is the low byte
  typedef logic [1:0] sel_t;

  // One request line per interrupt source
  typedef logic [7:0] irq_vec_t;

  // Interrupt number
  typedef logic [2:0] irq_id_t;

  // Master to slave, cyc/stb gated per slave by the switch
  typedef struct packed {
    word_t dat;
    addr_t adr;
    logic  tga;  // Set for I/O space
    sel_t  sel;
    logic  we;
    logic  cyc;
    logic  stb;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    word_t dat;
    logic  ack;
  } wb_rsp_t;

endpackage

// File: src/tick_timer.sv
// Periodic tick generator for the interrupt controller
`include "soc_params.svh"

module tick_timer (
  input  wb_clk_i,
  input  reset_i,
  output tick_o
);

  localparam int CNT_W = $clog2(`TIMER_PERIOD);

  typedef logic [CNT_W-1:0] cnt_t;

  localparam cnt_t LAST = cnt_t'(`TIMER_PERIOD - 1);

  cnt_t cnt_q;
  logic tick_q;
  logic wrap;

  assign wrap = (cnt_q == LAST);

  // Counts 0 to PERIOD-1, tick registered on the wrap
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      cnt_q  <= '0;
      tick_q <= 1'b0;
    end else begin
      tick_q <= wrap;
      if (wrap) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + cnt_t'(1);
      end
    end
  end

  assign tick_o = tick_q;

endmodule

// File: src/wb_switch.sv
// Address decoder and response multiplexer for one master, two slaves and a default slave
`include "soc_params.svh"

module wb_switch (
  input  soc_pkg::wb_req_t m_req_i,
  output soc_pkg::wb_rsp_t m_rsp_o,

  // Slave 0, on-chip RAM
  output soc_pkg::wb_req_t s0_req_o,
  input  soc_pkg::wb_rsp_t s0_rsp_i,

  // Slave 1, switches and LEDs
  output soc_pkg::wb_req_t s1_req_o,
  input  soc_pkg::wb_rsp_t s1_rsp_i
);

  // Unmapped reads return all ones
  localparam soc_pkg::word_t DEF_DATA = 16'hffff;

  logic [19:0] dec_key;
  logic        match0;
  logic        match1;
  logic        sel0;
  logic        sel1;
  logic        m_active;

  // Address and mask compare on the tagged address
  function automatic logic addr_hit(
    input logic [19:0] key,
    input logic [19:0] base,
    input logic [19:0] mask
  );
    return (key & mask) == base;
  endfunction

  assign dec_key  = {m_req_i.tga, m_req_i.adr};
  assign m_active = m_req_i.cyc & m_req_i.stb;

  assign match0 = addr_hit(dec_key, `S0_ADDR, `S0_MASK);
  assign match1 = addr_hit(dec_key, `S1_ADDR, `S1_MASK);

  // First match wins, S0 before S1
  assign sel0 = match0;
  assign sel1 = ~match0 & match1;

  // Request fields go everywhere, only cyc and stb are steered
  always_comb begin
    s0_req_o     = m_req_i;
    s0_req_o.cyc = m_req_i.cyc & sel0;
    s0_req_o.stb = m_req_i.stb & sel0;
  end

  always_comb begin
    s1_req_o     = m_req_i;
    s1_req_o.cyc = m_req_i.cyc & sel1;
    s1_req_o.stb = m_req_i.stb & sel1;
  end

  // Response mux
  // Default slave answers in the same cycle
  always_comb begin
    if (sel0) begin
      m_rsp_o = s0_rsp_i;
    end else if (sel1) begin
      m_rsp_o = s1_rsp_i;
    end else begin
      m_rsp_o.dat = DEF_DATA;
      m_rsp_o.ack = m_active;
    end
  end

endmodule
